// ==== verilog/inv_params.svh ====
`ifndef INV_PARAMS_SVH
`define INV_PARAMS_SVH

//////////////////////////////
// word sizes
//////////////////////////////

// operand and modulus width, 256 also works
`define INV_WIDTH 64

// signed coefficient width, two guard bits above the word
`define INV_COEF_WIDTH (`INV_WIDTH + 2)

//////////////////////////////
// step limits
//////////////////////////////

// each step removes at least one bit from u*v, plus some slack
`define INV_MAX_STEPS (2 * `INV_WIDTH + 4)

`endif

// ==== verilog/inv_pkg.sv ====
`include "inv_params.svh"

package inv_pkg;

    typedef logic [`INV_WIDTH-1:0]             word_t;
    typedef logic signed [`INV_COEF_WIDTH-1:0] coef_t;  // x1/x2, modulo p with guard bits

    // one reduction step, the coefficient side mirrors it
    typedef enum logic [2:0] {
        OP_NONE,
        OP_HALVE_U,
        OP_QUARTER_U,
        OP_HALVE_V,
        OP_QUARTER_V,
        OP_SUB_U,       // u <= (u - v) / 2
        OP_SUB_V        // v <= (v - u) / 2
    } step_op_e;

    typedef enum logic {
        ST_IDLE,
        ST_RUN
    } inv_state_e;

    typedef struct packed {
        word_t a;   // operand, sampled on start
        word_t p;   // odd modulus, held until done
    } inv_req_t;

    typedef struct packed {
        step_op_e op;
        logic     load;     // first cycle after start
    } step_t;

    typedef struct packed {
        logic valid;        // one-cycle pulse
        logic u_side;       // u reached 1, else v did
    } finish_t;

endpackage

// ==== verilog/uv_reducer.sv ====
`timescale 1ns/1ps
`include "inv_params.svh"

module uv_reducer
    import inv_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     start,     // also abandons a running operation
    input  inv_req_t req,
    output step_t    step,      // registered, coefficients follow one cycle later
    output finish_t  finish,
    output logic     busy
);

    inv_state_e state;
    word_t      u;
    word_t      v;
    word_t      u_next;
    word_t      v_next;
    step_op_e   op_sel;
    logic       u_is_one;
    logic       v_is_one;
    logic [$clog2(`INV_MAX_STEPS + 2)-1:0] run_cnt;   // cycles spent in ST_RUN

    assign u_is_one = (u == word_t'(1));
    assign v_is_one = (v == word_t'(1));

    //////////////////////////////
    // step decision
    //////////////////////////////

    always_comb begin
        op_sel = OP_NONE;
        if (u_is_one || v_is_one) begin
            op_sel = OP_NONE;                               // finished, hold
        end else if (!u[0]) begin
            op_sel = u[1] ? OP_HALVE_U : OP_QUARTER_U;      // 10 halves, 00 quarters
        end else if (!v[0]) begin
            op_sel = v[1] ? OP_HALVE_V : OP_QUARTER_V;
        end else if (u >= v) begin
            op_sel = OP_SUB_U;                              // tie goes to u
        end else begin
            op_sel = OP_SUB_V;
        end
    end

    always_comb begin
        u_next = u;
        v_next = v;
        case (op_sel)
            OP_HALVE_U:   u_next = u >> 1;
            OP_QUARTER_U: u_next = u >> 2;
            OP_HALVE_V:   v_next = v >> 1;
            OP_QUARTER_V: v_next = v >> 2;
            OP_SUB_U:     u_next = (u - v) >> 1;    // both odd, difference is even
            OP_SUB_V:     v_next = (v - u) >> 1;
            default:      ;
        endcase
    end

    //////////////////////////////
    // state and outputs
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state  <= ST_IDLE;
            step   <= '{op: OP_NONE, load: 1'b0};
            finish <= '{valid: 1'b0, u_side: 1'b0};
        end else if (start) begin
            state  <= ST_RUN;
            step   <= '{op: OP_NONE, load: 1'b1};   // coefficients reload next edge
            finish <= '{valid: 1'b0, u_side: 1'b0};
        end else if (state == ST_RUN) begin
            step <= '{op: op_sel, load: 1'b0};
            if (u_is_one || v_is_one) begin
                state  <= ST_IDLE;
                finish <= '{valid: 1'b1, u_side: u_is_one};
            end else begin
                finish.valid <= 1'b0;
            end
        end else begin
            step         <= '{op: OP_NONE, load: 1'b0};
            finish.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            u <= req.a;
            v <= req.p;
        end else if (state == ST_RUN) begin
            u <= u_next;
            v <= v_next;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            run_cnt <= '0;
        end else if (start) begin
            run_cnt <= '0;
        end else if (state == ST_RUN) begin
            run_cnt <= run_cnt + 1'b1;
        end
    end

    assign busy = (state == ST_RUN) || finish.valid;    // drops in the done cycle

    // coefficient side must see no step once the loop has stopped
    a_idle_no_step: assert property (@(posedge clk) disable iff (!rstn)
        (state == ST_IDLE) |-> (step.op == OP_NONE));

    // p is odd and every step keeps one side odd
    a_one_odd: assert property (@(posedge clk) disable iff (!rstn)
        (state == ST_RUN) |-> (u[0] || v[0]));

    a_run_bounded: assert property (@(posedge clk) disable iff (!rstn)
        (state == ST_RUN) |-> (run_cnt <= `INV_MAX_STEPS));

endmodule

// ==== verilog/coef_tracker.sv ====
`timescale 1ns/1ps
`include "inv_params.svh"

module coef_tracker
    import inv_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  step_t step,
    input  word_t p,
    output coef_t x1,
    output coef_t x2
);

    coef_t p_ext;
    coef_t p_half;      // floor(p/2)
    coef_t p_quarter;   // floor(p/4)
    coef_t x1_next;
    coef_t x2_next;

    assign p_ext     = {{(`INV_COEF_WIDTH - `INV_WIDTH){1'b0}}, p};
    assign p_half    = p_ext >>> 1;
    assign p_quarter = p_ext >>> 2;

    //////////////////////////////
    // modular shifts
    //////////////////////////////

    // x/2 mod p, odd x gets (p+1)/2 added after the shift
    function automatic coef_t half_mod(input coef_t x, input coef_t ph);
        coef_t h;
        h = x >>> 1;
        if (x[0])
            h = h + ph + coef_t'(1);
        return h;
    endfunction

    // x/4 mod p, adds (r + k*p)/4 with k chosen so that r + k*p is a multiple of 4
    function automatic coef_t quarter_mod(input coef_t x, input coef_t ph,
                                          input coef_t pq, input logic p_bit1);
        coef_t q;
        coef_t c;
        q = x >>> 2;
        case (x[1:0])
            2'b00:   c = '0;
            2'b10:   c = ph + coef_t'(1);
            2'b01:   c = p_bit1 ? pq + coef_t'(1) : pq + ph + coef_t'(1);     // k = 1 or 3
            default: c = p_bit1 ? pq + ph + coef_t'(2) : pq + coef_t'(1);     // k = 3 or 1
        endcase
        return q + c;
    endfunction

    // (a - b)/2 mod p, difference folded into 0..p-1 first
    function automatic coef_t sub_half_mod(input coef_t a, input coef_t b,
                                           input coef_t pe, input coef_t ph);
        coef_t d;
        d = a - b;
        if (d[`INV_COEF_WIDTH-1])
            d = d + pe;
        return half_mod(d, ph);
    endfunction

    //////////////////////////////
    // coefficient registers
    //////////////////////////////

    always_comb begin
        x1_next = x1;
        x2_next = x2;
        case (step.op)
            OP_HALVE_U:   x1_next = half_mod(x1, p_half);
            OP_QUARTER_U: x1_next = quarter_mod(x1, p_half, p_quarter, p[1]);
            OP_HALVE_V:   x2_next = half_mod(x2, p_half);
            OP_QUARTER_V: x2_next = quarter_mod(x2, p_half, p_quarter, p[1]);
            OP_SUB_U:     x1_next = sub_half_mod(x1, x2, p_ext, p_half);
            OP_SUB_V:     x2_next = sub_half_mod(x2, x1, p_ext, p_half);
            default:      ;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            x1 <= coef_t'(1);
            x2 <= '0;
        end else if (step.load) begin
            x1 <= coef_t'(1);   // a*1 = u
            x2 <= '0;           // a*0 = v mod p
        end else begin
            x1 <= x1_next;
            x2 <= x2_next;
        end
    end

    // p stays stable from start to done, so the bound holds after every step
    a_coef_range: assert property (@(posedge clk) disable iff (!rstn)
        (step.op != OP_NONE) |=>
            (x1 >= -p_ext) && (x1 < (p_ext <<< 1)) &&
            (x2 >= -p_ext) && (x2 < (p_ext <<< 1)));

endmodule

// ==== verilog/inv_result.sv ====
`timescale 1ns/1ps
`include "inv_params.svh"

module inv_result
    import inv_pkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  finish_t finish,
    input  coef_t   x1,
    input  coef_t   x2,
    input  word_t   p,
    output word_t   a_inv,
    output logic    done
);

    coef_t p_ext;
    coef_t sel;
    coef_t norm;

    assign p_ext = {{(`INV_COEF_WIDTH - `INV_WIDTH){1'b0}}, p};

    //////////////////////////////
    // normalize into 0..p-1
    //////////////////////////////

    always_comb begin
        sel = finish.u_side ? x1 : x2;      // coefficient of the side that hit 1
        if (sel[`INV_COEF_WIDTH-1]) begin
            norm = sel + p_ext;             // negative
        end else if (sel >= p_ext) begin
            norm = sel - p_ext;
        end else begin
            norm = sel;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            a_inv <= '0;
            done  <= 1'b0;
        end else begin
            done <= finish.valid;
            if (finish.valid)
                a_inv <= norm[`INV_WIDTH-1:0];  // guard bits are zero here
        end
    end

    // registered result stays below the modulus
    a_result_range: assert property (@(posedge clk) disable iff (!rstn)
        done |-> (a_inv < p));

endmodule

// ==== verilog/mod_inv_top.sv ====
`timescale 1ns/1ps
`include "inv_params.svh"

module mod_inv_top
    import inv_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     start,     // one-cycle strobe
    input  inv_req_t req,       // p held from start until done
    output word_t    a_inv,
    output logic     done,
    output logic     busy
);

    step_t   step;
    finish_t finish;
    coef_t   x1;
    coef_t   x2;

    //////////////////////////////
    // u,v loop
    //////////////////////////////

    uv_reducer i_uv_reducer (
        .clk    (clk),
        .rstn   (rstn),
        .start  (start),
        .req    (req),
        .step   (step),
        .finish (finish),
        .busy   (busy)
    );

    // mirrors each step on x1,x2 one cycle later
    coef_tracker i_coef_tracker (
        .clk  (clk),
        .rstn (rstn),
        .step (step),
        .p    (req.p),
        .x1   (x1),
        .x2   (x2)
    );

    //////////////////////////////
    // result
    //////////////////////////////

    inv_result i_inv_result (
        .clk    (clk),
        .rstn   (rstn),
        .finish (finish),
        .x1     (x1),
        .x2     (x2),
        .p      (req.p),
        .a_inv  (a_inv),
        .done   (done)
    );

endmodule

// ==== tests/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset released on a rising edge
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

// ==== tests/tb_mod_inv.sv ====
`timescale 1ns/1ps
`include "inv_params.svh"

module tb_mod_inv
    import inv_pkg::*;
();

    typedef logic [2*`INV_WIDTH-1:0]        dword_t;
    typedef logic signed [2*`INV_WIDTH+1:0] wide_t;     // wide enough for the reference loop

    typedef struct packed {
        word_t a;
        word_t p;
        word_t inv;
    } expect_t;

    localparam int     LAT_LIMIT   = `INV_MAX_STEPS + 3;
    localparam int     NUM_RANDOM  = 30;
    localparam int     NUM_OPS     = 3 * (3 + NUM_RANDOM + 2);   // edge, random and restart ops
    localparam longint WATCHDOG_NS = longint'(NUM_OPS) * (`INV_MAX_STEPS + 10) * 40 + 400;

    logic     clk;
    logic     rstn;
    logic     start;
    inv_req_t req;
    word_t    a_inv;
    logic     done;
    logic     busy;

    expect_t     exp_q[$];      // filled by stimulus and read in order by the checker
    int          rd_idx = 0;
    expect_t     cur;
    dword_t      prod;
    word_t       last_inv = '0;
    logic        last_done = 1'b0;
    logic [31:0] lfsr_state = 32'ha1a6;
    word_t       moduli[3];
    int          stim_errors = 0;
    int          stim_checks = 0;
    int          chk_errors = 0;
    int          chk_checks = 0;

    tb_clkgen #(.PERIOD_NS(40), .RESET_CYCLES(5)) i_clkgen (.clk(clk), .rstn(rstn));

    mod_inv_top i_dut (
        .clk   (clk),
        .rstn  (rstn),
        .start (start),
        .req   (req),
        .a_inv (a_inv),
        .done  (done),
        .busy  (busy)
    );

    //////////////////////////////
    // random source and reference
    //////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);     // x^32+x^22+x^2+x+1
    endfunction

    function automatic word_t random_word();
        word_t w;
        w = '0;
        for (int i = 0; i < `INV_WIDTH; i++) begin
            lfsr_state = lfsr_next(lfsr_state);     // one step per bit
            w = {w[`INV_WIDTH-2:0], lfsr_state[0]};
        end
        return w;
    endfunction

    // extended Euclid on signed values where t tracks the coefficient of a
    function automatic word_t ref_inverse(input word_t op_a, input word_t mod_p);
        wide_t r0;
        wide_t r1;
        wide_t t0;
        wide_t t1;
        wide_t q;
        wide_t tmp;
        r0 = wide_t'(mod_p);
        r1 = wide_t'(op_a);
        t0 = '0;
        t1 = wide_t'(1);
        while (r1 != '0) begin
            q   = r0 / r1;
            tmp = r0 - q * r1;
            r0  = r1;
            r1  = tmp;
            tmp = t0 - q * t1;
            t0  = t1;
            t1  = tmp;
        end
        if (t0[2*`INV_WIDTH+1])
            t0 = t0 + wide_t'(mod_p);
        return word_t'(t0);
    endfunction

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic issue_start(input word_t op_a, input word_t mod_p, input logic from_idle);
        @(posedge clk);
        req   <= '{a: op_a, p: mod_p};
        start <= 1'b1;
        @(negedge clk);
        stim_checks++;
        if (from_idle && busy !== 1'b0) begin
            $display("FAIL %0t busy expected 0 got %b", $time, busy);
            stim_errors++;
        end
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        stim_checks++;
        if (busy !== 1'b1) begin   // one cycle after start was sampled
            $display("FAIL %0t busy expected 1 got %b", $time, busy);
            stim_errors++;
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 1;
        while (done !== 1'b1 && cycles < LAT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        stim_checks++;
        if (done !== 1'b1) begin
            $display("no done within %0d cycles of start, at %0t", LAT_LIMIT, $time);
            stim_errors++;
        end
    endtask

    task automatic run_op(input word_t op_a, input word_t mod_p, input word_t expv);
        exp_q.push_back('{a: op_a, p: mod_p, inv: expv});
        issue_start(op_a, mod_p, 1'b1);
        wait_done();
    endtask

    // second start while busy so that only the second operand finishes
    task automatic run_restart(input word_t a_first, input word_t a_second, input word_t mod_p);
        exp_q.push_back('{a: a_second, p: mod_p, inv: ref_inverse(a_second, mod_p)});
        issue_start(a_first, mod_p, 1'b1);
        repeat (2) @(negedge clk);
        stim_checks++;
        if (busy !== 1'b1) begin
            $display("first operation ended before the restart at %0t", $time);
            stim_errors++;
        end
        issue_start(a_second, mod_p, 1'b0);
        wait_done();
        repeat (LAT_LIMIT) @(negedge clk);  // room for a stray done
    endtask

    initial begin
        word_t p;
        word_t a;
        word_t a2;
        $timeformat(-9, 0, " ns", 0);
        start <= 1'b0;
        req   <= '0;
        moduli[0] = (word_t'(1) << 31) - word_t'(1);
        moduli[1] = (word_t'(1) << 61) - word_t'(1);
        moduli[2] = (word_t'(1) << 64) - word_t'(59);
        wait (rstn === 1'b1);
        @(negedge clk);
        stim_checks++;
        if (busy !== 1'b0) begin
            $display("FAIL %0t busy expected 0 got %b", $time, busy);
            stim_errors++;
        end
        if (done !== 1'b0) begin
            $display("FAIL %0t done expected 0 got %b", $time, done);
            stim_errors++;
        end
        if (a_inv !== '0) begin
            $display("FAIL %0t a_inv expected 0 got %0h", $time, a_inv);
            stim_errors++;
        end
        for (int m = 0; m < 3; m++) begin
            p = moduli[m];
            run_op(word_t'(1), p, word_t'(1));
            run_op(p - word_t'(1), p, p - word_t'(1));
            run_op(word_t'(2), p, (p + word_t'(1)) / word_t'(2));
            for (int i = 0; i < NUM_RANDOM; i++) begin
                a = (random_word() % (p - word_t'(1))) + word_t'(1);
                run_op(a, p, ref_inverse(a, p));
            end
            a  = (random_word() % (p - word_t'(1))) + word_t'(1);
            a2 = (random_word() % (p - word_t'(1))) + word_t'(1);
            run_restart(a, a2, p);
        end
        repeat (5) @(negedge clk);
        stim_checks++;
        if (rd_idx != exp_q.size()) begin
            $display("%0d operations never produced done", exp_q.size() - rd_idx);
            stim_errors++;
        end
        $display("checks %0d, errors %0d (stimulus %0d, results %0d)",
                 stim_checks + chk_checks, stim_errors + chk_errors, stim_errors, chk_errors);
        if (stim_errors + chk_errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    //////////////////////////////
    // result checker
    //////////////////////////////

    always @(negedge clk) begin
        if (rstn) begin
            if (done) begin
                chk_checks++;
                if (busy !== 1'b0) begin
                    $display("FAIL %0t busy expected 0 got %b", $time, busy);
                    chk_errors++;
                end
                if (last_done) begin
                    $display("done stayed high for a second cycle at %0t", $time);
                    chk_errors++;
                end
                if (rd_idx >= exp_q.size()) begin
                    $display("done at %0t with no operation pending", $time);
                    chk_errors++;
                end else begin
                    cur = exp_q[rd_idx];
                    rd_idx++;
                    if (a_inv !== cur.inv) begin
                        $display("FAIL %0t a_inv expected %0h got %0h", $time, cur.inv, a_inv);
                        chk_errors++;
                    end
                    if (a_inv >= cur.p) begin
                        $display("FAIL %0t a_inv expected below %0h got %0h",
                                 $time, cur.p, a_inv);
                        chk_errors++;
                    end
                    prod = (dword_t'(cur.a) * dword_t'(a_inv)) % dword_t'(cur.p);
                    if (prod !== dword_t'(1)) begin
                        $display("FAIL %0t a*a_inv mod p expected 1 got %0h", $time, prod);
                        chk_errors++;
                    end
                end
                last_inv = a_inv;
            end else if (a_inv !== last_inv) begin   // must hold between results
                $display("FAIL %0t a_inv expected %0h got %0h", $time, last_inv, a_inv);
                chk_errors++;
                last_inv = a_inv;
            end
            last_done = done;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, simulation stopped", $time);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/inv_pkg.sv
verilog/uv_reducer.sv
verilog/coef_tracker.sv
verilog/inv_result.sv
verilog/mod_inv_top.sv
tests/tb_clkgen.sv
tests/tb_mod_inv.sv

// ==== Makefile ====
# Verilator build and run for the modular inverter

VERILATOR ?= verilator
TOP       ?= tb_mod_inv
RTL_TOP   ?= mod_inv_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failed
VFLAGS    ?= --binary --timing --assert -j 0
RTL_SRCS  ?= verilog/inv_pkg.sv verilog/uv_reducer.sv verilog/coef_tracker.sv \
             verilog/inv_result.sv verilog/mod_inv_top.sv
TB_SRCS   ?= tests/tb_clkgen.sv tests/tb_mod_inv.sv

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(RTL_SRCS) $(TB_SRCS) verilog/inv_params.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall -Iverilog $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
